// ==== include/fspu_macros.svh ====
`ifndef FSPU_MACROS_SVH
`define FSPU_MACROS_SVH

// Register width and destination tag width
`define FSPU_XLEN      64
`define FSPU_TAG_W     6

// IEEE fields are laid out as {sign, exponent, fraction}
// Fraction starts at bit 0 and the sign is the top bit of the format

// Double precision
`define FSPU_D_EXP_W   11
`define FSPU_D_FRAC_W  52
`define FSPU_D_BIAS    1023

// Single precision, held in the low word of a 64-bit register
`define FSPU_S_EXP_W   8
`define FSPU_S_FRAC_W  23
`define FSPU_S_BIAS    127

`endif

// ==== design/fspu_pkg.sv ====
`default_nettype none

`include "fspu_macros.svh"

package fspu_pkg;

  // Opcodes accepted on the issue port
  // Codes 4'ha through 4'hf are reserved and produce a zero result
  typedef enum logic [3:0] {
    FMV_VF = 4'h0,
    FMV_FF = 4'h1,
    FMV_FH = 4'h2,
    FMV_XH = 4'h3,
    FLOGB  = 4'h4,
    FCLASS = 4'h5,
    FSEL   = 4'h6,
    FSGNJ  = 4'h7,
    FSGNJN = 4'h8,
    FSGNJX = 4'h9
  } fspu_opcode_e;

  // Issue request
  typedef struct packed {
    fspu_opcode_e            opcode;
    logic                    fmt_single;
    logic                    fsel_cond;
    logic [`FSPU_XLEN-1:0]   oper0;
    logic [`FSPU_XLEN-1:0]   oper1;
    // Integer register source for moves into FP registers
    logic [`FSPU_XLEN-1:0]   mtvr_src0;
    logic [`FSPU_TAG_W-1:0]  tag;
  } fspu_req_t;

  // One-hot operation strobes, one set per format path
  typedef struct packed {
    logic op_fmvvf;
    logic op_fmvff;
    logic op_fmvfh;
    logic op_fmvxh;
    logic op_flog;
    logic op_class;
    logic op_fsel;
    // Select condition, only meaningful with op_fsel
    logic op_fselc;
    logic op_fsgnj;
    logic op_fsgnjn;
    logic op_fsgnjx;
  } fspu_op_t;

  // Result handed back to the register file writeback
  typedef struct packed {
    logic [`FSPU_XLEN-1:0]   data;
    logic [`FSPU_TAG_W-1:0]  tag;
  } fspu_rslt_t;

endpackage

`default_nettype wire

// ==== design/fspu_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fspu_pipe_reg #(
  parameter type T = fspu_pkg::fspu_req_t
) (
  input  logic forever_cpuclk,
  input  logic rst_n,
  input  logic d_vld,
  input  T     d,
  output logic q_vld,
  output T     q
);

  // Valid bit
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      q_vld <= 1'b0;
    end else begin
      q_vld <= d_vld;
    end
  end

  // Payload only moves when a request is present
  always_ff @(posedge forever_cpuclk) begin
    if (d_vld) begin
      q <= d;
    end
  end

  // Valid must be a clean 0 or 1 once out of reset
  q_vld_known: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) !$isunknown(q_vld)
  ) else $error("fspu_pipe_reg: q_vld is unknown");

  // Upstream stage must have handed over a fully known payload
  q_known_when_vld: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) q_vld |-> !$isunknown(q)
  ) else $error("fspu_pipe_reg: payload unknown while q_vld is high");

endmodule

`default_nettype wire

// ==== design/fspu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fspu_decode (
  input  fspu_pkg::fspu_req_t req,
  output fspu_pkg::fspu_op_t  dbl_op,
  output fspu_pkg::fspu_op_t  sgl_op
);

  // Strobes whose path is picked by the format bit
  localparam fspu_pkg::fspu_op_t FMT_OPS = '{
    op_flog:   1'b1,
    op_class:  1'b1,
    op_fsgnj:  1'b1,
    op_fsgnjn: 1'b1,
    op_fsgnjx: 1'b1,
    default:   1'b0
  };

  localparam fspu_pkg::fspu_op_t SEL_COND = '{op_fselc: 1'b1, default: 1'b0};

  fspu_pkg::fspu_op_t all_op;
  logic [21:0]        strobes;

  // Format-independent one-hot decode
  always_comb begin
    all_op = '0;
    case (req.opcode)
      fspu_pkg::FMV_VF: all_op.op_fmvvf = 1'b1;
      fspu_pkg::FMV_FF: all_op.op_fmvff = 1'b1;
      fspu_pkg::FMV_FH: all_op.op_fmvfh = 1'b1;
      fspu_pkg::FMV_XH: all_op.op_fmvxh = 1'b1;
      fspu_pkg::FLOGB:  all_op.op_flog  = 1'b1;
      fspu_pkg::FCLASS: all_op.op_class = 1'b1;
      fspu_pkg::FSEL: begin
        all_op.op_fsel  = 1'b1;
        all_op.op_fselc = req.fsel_cond;
      end
      fspu_pkg::FSGNJ:  all_op.op_fsgnj  = 1'b1;
      fspu_pkg::FSGNJN: all_op.op_fsgnjn = 1'b1;
      fspu_pkg::FSGNJX: all_op.op_fsgnjx = 1'b1;
      default:          all_op = '0;
    endcase
  end

  // Moves and select always run on the double path
  assign sgl_op = req.fmt_single ? (all_op & FMT_OPS) : '0;
  assign dbl_op = req.fmt_single ? (all_op & ~FMT_OPS) : all_op;

  assign strobes = {dbl_op & ~SEL_COND, sgl_op & ~SEL_COND};

  // Path results are ORed in ex1, so never more than one strobe
  always_comb begin
    if (!$isunknown({req.opcode, req.fmt_single})) begin
      assert ($onehot0(strobes))
        else $error("fspu_decode: more than one operation strobe set");
    end
  end

endmodule

`default_nettype wire

// ==== design/fspu_double.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fspu_macros.svh"

module fspu_double (
  input  fspu_pkg::fspu_op_t     op,
  input  logic [`FSPU_XLEN-1:0]  oper0,
  input  logic [`FSPU_XLEN-1:0]  oper1,
  input  logic [`FSPU_XLEN-1:0]  mtvr_src0,
  output logic [`FSPU_XLEN-1:0]  result
);

  localparam int XL = `FSPU_XLEN;
  localparam int HW = `FSPU_XLEN / 2;
  localparam int EW = `FSPU_D_EXP_W;
  localparam int FW = `FSPU_D_FRAC_W;

  localparam logic [XL-1:0] D_QNAN    = {1'b0, {EW{1'b1}}, 1'b1, {(FW-1){1'b0}}};
  localparam logic [XL-1:0] D_NEG_INF = {1'b1, {EW{1'b1}}, {FW{1'b0}}};

  logic          sign0;
  logic [EW-1:0] exp0;
  logic [FW-1:0] frac0;
  logic          exp_max;
  logic          exp_zero;
  logic          frac_zero;
  logic [9:0]    cls;
  logic          is_nan;
  logic          is_zero;
  logic          flog_int;
  logic          flog_neg;
  logic [EW-1:0] unb_exp;
  logic [XL-1:0] res_class;
  logic [XL-1:0] res_sgnj;
  logic [XL-1:0] res_sgnjn;
  logic [XL-1:0] res_sgnjx;
  logic [XL-1:0] res_fmvfh;
  logic [XL-1:0] res_fmvxh;
  logic [XL-1:0] res_fsel;
  logic [XL-1:0] res_flog;

  assign {sign0, exp0, frac0} = oper0;

  assign exp_max   = &exp0;
  assign exp_zero  = ~|exp0;
  assign frac_zero = ~|frac0;

  // Class mask, sNaN at bit 0 up to +0 at bit 9
  assign cls[0] = exp_max & ~frac_zero & ~frac0[FW-1];
  assign cls[1] = exp_max & frac0[FW-1];
  assign cls[2] = sign0 & exp_max & frac_zero;
  assign cls[3] = sign0 & ~exp_max & ~exp_zero;
  assign cls[4] = sign0 & exp_zero & ~frac_zero;
  assign cls[5] = sign0 & exp_zero & frac_zero;
  assign cls[6] = ~sign0 & exp_max & frac_zero;
  assign cls[7] = ~sign0 & ~exp_max & ~exp_zero;
  assign cls[8] = ~sign0 & exp_zero & ~frac_zero;
  assign cls[9] = ~sign0 & exp_zero & frac_zero;

  assign res_class = {{(XL-10){1'b0}}, cls};

  // Sign injection keeps the magnitude of oper0
  assign res_sgnj  = {oper1[XL-1], oper0[XL-2:0]};
  assign res_sgnjn = {~oper1[XL-1], oper0[XL-2:0]};
  assign res_sgnjx = {sign0 ^ oper1[XL-1], oper0[XL-2:0]};

  // Word moves between halves
  assign res_fmvfh = {oper0[HW-1:0], oper1[HW-1:0]};
  assign res_fmvxh = {{HW{oper0[XL-1]}}, oper0[XL-1:HW]};

  assign res_fsel = op.op_fselc ? oper1 : oper0;

  // FLOGB
  assign is_nan  = cls[0] | cls[1];
  assign is_zero = cls[5] | cls[9];
  // Positive finite non-zero, subnormals give the raw field minus bias
  assign flog_int = ~sign0 & ~exp_max & ~is_zero;
  assign flog_neg = sign0 & ~is_nan & ~is_zero;
  assign unb_exp  = exp0 - EW'(`FSPU_D_BIAS);

  assign res_flog = {XL{flog_int}}          & {{(XL-EW){unb_exp[EW-1]}}, unb_exp}
                  | {XL{flog_neg}}          & D_QNAN
                  | {XL{is_zero}}           & D_NEG_INF
                  | {XL{cls[1] | cls[6]}}   & oper0
                  | {XL{cls[0]}}            & {sign0, exp0, 1'b1, frac0[FW-2:0]};

  // Final AND-OR mux
  assign result = {XL{op.op_fmvvf}}  & mtvr_src0
                | {XL{op.op_fmvff}}  & oper0
                | {XL{op.op_fmvfh}}  & res_fmvfh
                | {XL{op.op_fmvxh}}  & res_fmvxh
                | {XL{op.op_fsel}}   & res_fsel
                | {XL{op.op_flog}}   & res_flog
                | {XL{op.op_class}}  & res_class
                | {XL{op.op_fsgnj}}  & res_sgnj
                | {XL{op.op_fsgnjn}} & res_sgnjn
                | {XL{op.op_fsgnjx}} & res_sgnjx;

endmodule

`default_nettype wire

// ==== design/fspu_single.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fspu_macros.svh"

module fspu_single (
  input  fspu_pkg::fspu_op_t     op,
  input  logic [`FSPU_XLEN-1:0]  oper0,
  input  logic [`FSPU_XLEN-1:0]  oper1,
  output logic [`FSPU_XLEN-1:0]  result
);

  localparam int XL = `FSPU_XLEN;
  localparam int EW = `FSPU_S_EXP_W;
  localparam int FW = `FSPU_S_FRAC_W;
  localparam int SW = 1 + EW + FW;

  localparam logic [SW-1:0] S_QNAN    = {1'b0, {EW{1'b1}}, 1'b1, {(FW-1){1'b0}}};
  localparam logic [SW-1:0] S_NEG_INF = {1'b1, {EW{1'b1}}, {FW{1'b0}}};

  // Upper word of every boxed single result
  localparam logic [XL-SW-1:0] BOX = '1;

  logic          sign0;
  logic [EW-1:0] exp0;
  logic [FW-1:0] frac0;
  logic          exp_max;
  logic          exp_zero;
  logic          frac_zero;
  logic [9:0]    cls;
  logic          is_nan;
  logic          is_zero;
  logic          flog_int;
  logic          flog_neg;
  logic [EW-1:0] unb_exp;
  logic [SW-1:0] res_flog;

  // Only the low word carries the single operand
  assign {sign0, exp0, frac0} = oper0[SW-1:0];

  assign exp_max   = &exp0;
  assign exp_zero  = ~|exp0;
  assign frac_zero = ~|frac0;

  // Same bit order as the double classify mask
  assign cls[0] = exp_max & ~frac_zero & ~frac0[FW-1];
  assign cls[1] = exp_max & frac0[FW-1];
  assign cls[2] = sign0 & exp_max & frac_zero;
  assign cls[3] = sign0 & ~exp_max & ~exp_zero;
  assign cls[4] = sign0 & exp_zero & ~frac_zero;
  assign cls[5] = sign0 & exp_zero & frac_zero;
  assign cls[6] = ~sign0 & exp_max & frac_zero;
  assign cls[7] = ~sign0 & ~exp_max & ~exp_zero;
  assign cls[8] = ~sign0 & exp_zero & ~frac_zero;
  assign cls[9] = ~sign0 & exp_zero & frac_zero;

  // FLOGB, 32-bit integer in the low word
  assign is_nan   = cls[0] | cls[1];
  assign is_zero  = cls[5] | cls[9];
  assign flog_int = ~sign0 & ~exp_max & ~is_zero;
  assign flog_neg = sign0 & ~is_nan & ~is_zero;
  assign unb_exp  = exp0 - EW'(`FSPU_S_BIAS);

  assign res_flog = {SW{flog_int}}        & {{(SW-EW){unb_exp[EW-1]}}, unb_exp}
                  | {SW{flog_neg}}        & S_QNAN
                  | {SW{is_zero}}         & S_NEG_INF
                  | {SW{cls[1] | cls[6]}} & oper0[SW-1:0]
                  | {SW{cls[0]}}          & {sign0, exp0, 1'b1, frac0[FW-2:0]};

  // Class mask is zero-extended, everything else is boxed
  assign result = {XL{op.op_class}}  & {{(XL-10){1'b0}}, cls}
                | {XL{op.op_flog}}   & {BOX, res_flog}
                | {XL{op.op_fsgnj}}  & {BOX, oper1[SW-1], oper0[SW-2:0]}
                | {XL{op.op_fsgnjn}} & {BOX, ~oper1[SW-1], oper0[SW-2:0]}
                | {XL{op.op_fsgnjx}} & {BOX, sign0 ^ oper1[SW-1], oper0[SW-2:0]};

endmodule

`default_nettype wire

// ==== design/fspu_ex1_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fspu_macros.svh"

module fspu_ex1_stage (
  input  fspu_pkg::fspu_req_t  req,
  output fspu_pkg::fspu_rslt_t rslt
);

  fspu_pkg::fspu_op_t     dbl_op;
  fspu_pkg::fspu_op_t     sgl_op;
  logic [`FSPU_XLEN-1:0]  dbl_result;
  logic [`FSPU_XLEN-1:0]  sgl_result;

  // Opcode and format to per-path strobes
  fspu_decode u_decode (
    .req    (req),
    .dbl_op (dbl_op),
    .sgl_op (sgl_op)
  );

  // Double path also owns moves and select
  fspu_double u_double (
    .op        (dbl_op),
    .oper0     (req.oper0),
    .oper1     (req.oper1),
    .mtvr_src0 (req.mtvr_src0),
    .result    (dbl_result)
  );

  fspu_single u_single (
    .op     (sgl_op),
    .oper0  (req.oper0),
    .oper1  (req.oper1),
    .result (sgl_result)
  );

  // Only one path has a strobe up, the idle one drives zero
  assign rslt.data = dbl_result | sgl_result;
  assign rslt.tag  = req.tag;

endmodule

`default_nettype wire

// ==== design/fspu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fspu_top (
  input  logic                 forever_cpuclk,
  input  logic                 rst_n,
  input  logic                 in_vld,
  input  fspu_pkg::fspu_req_t  in_req,
  output logic                 out_vld,
  output fspu_pkg::fspu_rslt_t out_rslt
);

  logic                 ex1_vld;
  fspu_pkg::fspu_req_t  ex1_req;
  fspu_pkg::fspu_rslt_t ex1_rslt;

  // Issue into ex1
  fspu_pipe_reg #(
    .T (fspu_pkg::fspu_req_t)
  ) u_issue_reg (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .d_vld          (in_vld),
    .d              (in_req),
    .q_vld          (ex1_vld),
    .q              (ex1_req)
  );

  // Decode and both datapaths
  fspu_ex1_stage u_ex1 (
    .req  (ex1_req),
    .rslt (ex1_rslt)
  );

  // ex1 into ex2, drives the result port
  fspu_pipe_reg #(
    .T (fspu_pkg::fspu_rslt_t)
  ) u_ex2_reg (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .d_vld          (ex1_vld),
    .d              (ex1_rslt),
    .q_vld          (out_vld),
    .q              (out_rslt)
  );

endmodule

`default_nettype wire

// ==== bench/tb_fspu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fspu_macros.svh"

module tb_fspu;

  localparam int RAND_REQS = 400;
  // Reset, directed and random phases stay under 1000 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  // +0 -0 +sub -sub +norm -norm +inf -inf sNaN -qNaN max_norm min_norm
  localparam logic [63:0] D_SPECIALS [12] = '{
    64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001,
    64'h800f_ffff_ffff_ffff, 64'h4059_0000_0000_0000, 64'hc000_0000_0000_0000,
    64'h7ff0_0000_0000_0000, 64'hfff0_0000_0000_0000, 64'h7ff0_0000_0000_0001,
    64'hfff8_0000_0000_0000, 64'h7fef_ffff_ffff_ffff, 64'h0010_0000_0000_0000};
  localparam logic [63:0] S_SPECIALS [12] = '{
    64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000, 64'hffff_ffff_0000_0001,
    64'hffff_ffff_807f_ffff, 64'hffff_ffff_3f80_0000, 64'hffff_ffff_c040_0000,
    64'hffff_ffff_7f80_0000, 64'hffff_ffff_ff80_0000, 64'hffff_ffff_7f80_0001,
    64'hffff_ffff_7fc0_0000, 64'hffff_ffff_7f7f_ffff, 64'hffff_ffff_0080_0000};

  logic                   forever_cpuclk;
  logic                   rst_n;
  logic                   in_vld;
  fspu_pkg::fspu_req_t    in_req;
  logic                   out_vld;
  fspu_pkg::fspu_rslt_t   out_rslt;

  // Expected results in issue order, rd_idx points at the oldest outstanding one
  fspu_pkg::fspu_rslt_t   exp_q[$];
  fspu_pkg::fspu_rslt_t   exp_head = '0;
  logic                   exp_avail = 1'b0;
  int                     rd_idx = 0;
  logic [1:0]             issue_hist;
  logic [`FSPU_TAG_W-1:0] next_tag;
  int                     err_cnt = 0;
  int                     tests_passed;
  int                     tests_failed;
  int                     cycle_cnt = 0;

  fspu_top uut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (in_vld),
    .in_req         (in_req),
    .out_vld        (out_vld),
    .out_rslt       (out_rslt)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #20 forever_cpuclk = ~forever_cpuclk;
  end

  // Outputs change on the rising edge, so all checks sample on the falling edge
  reset_quiet: assert property (@(negedge forever_cpuclk) !rst_n |-> !out_vld)
    else begin
      err_cnt++;
      $display("out_vld was high while reset was asserted");
    end

  latency_two: assert property (
    @(negedge forever_cpuclk) disable iff (!rst_n) out_vld == issue_hist[1]
  ) else begin
    err_cnt++;
    $display("mismatch out_vld: expected %h, got %h", issue_hist[1], out_vld);
  end

  no_stray_result: assert property (
    @(negedge forever_cpuclk) disable iff (!rst_n) out_vld |-> exp_avail
  ) else begin
    err_cnt++;
    $display("out_vld raised with no request in flight");
  end

  data_match: assert property (
    @(negedge forever_cpuclk) disable iff (!rst_n)
    (out_vld && exp_avail) |-> out_rslt.data == exp_head.data
  ) else begin
    err_cnt++;
    $display("mismatch out_rslt.data: expected %h, got %h", exp_head.data, out_rslt.data);
  end

  tag_match: assert property (
    @(negedge forever_cpuclk) disable iff (!rst_n)
    (out_vld && exp_avail) |-> out_rslt.tag == exp_head.tag
  ) else begin
    err_cnt++;
    $display("mismatch out_rslt.tag: expected %h, got %h", exp_head.tag, out_rslt.tag);
  end

  // Issue history, bit 1 is the in_vld sampled at the edge before the last one
  always @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      issue_hist <= '0;
    end else begin
      issue_hist <= {issue_hist[0], in_vld};
    end
  end

  // Retire the result checked at the last falling edge
  always @(posedge forever_cpuclk) begin
    if (rst_n && out_vld && exp_avail) begin
      rd_idx = rd_idx + 1;
    end
    exp_avail = (rd_idx < exp_q.size());
    if (exp_avail) begin
      exp_head = exp_q[rd_idx];
    end
  end

  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // Class bit index: sNaN 0, qNaN 1, then -inf -norm -sub -0 +inf +norm +sub +0
  function automatic logic [9:0] fclass_mask(input logic [63:0] v, input bit single);
    logic        sgn;
    logic [10:0] e;
    logic [10:0] e_max;
    logic [51:0] f;
    int          idx;
    if (single) begin
      sgn   = v[31];
      e     = 11'(v[`FSPU_S_FRAC_W +: `FSPU_S_EXP_W]);
      e_max = 11'd255;
      f     = {v[`FSPU_S_FRAC_W-1:0], 29'h0};
    end else begin
      sgn   = v[63];
      e     = v[`FSPU_D_FRAC_W +: `FSPU_D_EXP_W];
      e_max = 11'h7ff;
      f     = v[`FSPU_D_FRAC_W-1:0];
    end
    if (e == e_max && f != '0) idx = f[51] ? 1 : 0;
    else if (e == e_max) idx = sgn ? 2 : 6;
    else if (e == '0) idx = (f == '0) ? (sgn ? 5 : 9) : (sgn ? 4 : 8);
    else idx = sgn ? 3 : 7;
    return 10'b1 << idx;
  endfunction

  function automatic logic [63:0] flogb_ref(input logic [63:0] v, input bit single);
    logic [9:0]  cls;
    logic [63:0] x;
    logic [63:0] res;
    int          expo;
    cls  = fclass_mask(v, single);
    x    = single ? {32'h0, v[31:0]} : v;
    expo = single ? int'(v[30:23]) - `FSPU_S_BIAS : int'(v[62:52]) - `FSPU_D_BIAS;
    if (cls[0]) res = x | (64'd1 << (single ? 22 : 51));
    else if (cls[1] || cls[6]) res = x;
    else if (cls[5] || cls[9]) res = single ? 64'hff80_0000 : 64'hfff0_0000_0000_0000;
    else if (cls[2] || cls[3] || cls[4]) res = single ? 64'h7fc0_0000 : 64'h7ff8_0000_0000_0000;
    else res = 64'(expo);
    return single ? {32'hffff_ffff, res[31:0]} : res;
  endfunction

  function automatic logic [63:0] expected_data(input fspu_pkg::fspu_req_t r);
    logic [63:0] res;
    int          top;
    top = r.fmt_single ? 31 : 63;
    res = r.oper0;
    case (r.opcode)
      fspu_pkg::FMV_VF: res = r.mtvr_src0;
      fspu_pkg::FMV_FF: res = r.oper0;
      fspu_pkg::FMV_FH: res = {r.oper0[31:0], r.oper1[31:0]};
      fspu_pkg::FMV_XH: res = {{32{r.oper0[63]}}, r.oper0[63:32]};
      fspu_pkg::FSEL:   res = r.fsel_cond ? r.oper1 : r.oper0;
      fspu_pkg::FCLASS: res = 64'(fclass_mask(r.oper0, r.fmt_single));
      fspu_pkg::FLOGB:  res = flogb_ref(r.oper0, r.fmt_single);
      fspu_pkg::FSGNJ:  res[top] = r.oper1[top];
      fspu_pkg::FSGNJN: res[top] = ~r.oper1[top];
      fspu_pkg::FSGNJX: res[top] = r.oper0[top] ^ r.oper1[top];
      default:          res = '0;
    endcase
    // Single sign injection results are NaN-boxed
    if (r.fmt_single && (r.opcode == fspu_pkg::FSGNJ || r.opcode == fspu_pkg::FSGNJN ||
                         r.opcode == fspu_pkg::FSGNJX)) begin
      res[63:32] = '1;
    end
    return res;
  endfunction

  // Exponents are pulled toward zero, one, max-1 and all ones
  function automatic logic [63:0] rand_operand(input bit single);
    logic [63:0] v;
    logic [10:0] e;
    logic        clr;
    v   = {$urandom, $urandom};
    clr = ($urandom_range(0, 3) == 0);
    case ($urandom_range(0, 5))
      0: e = '0;
      1: e = '1;
      2: e = 11'h001;
      3: e = 11'h7fe;
      default: e = 11'($urandom);
    endcase
    if (single) begin
      v[`FSPU_S_FRAC_W +: `FSPU_S_EXP_W] = e[`FSPU_S_EXP_W-1:0];
      if (clr) v[`FSPU_S_FRAC_W-1:0] = '0;
    end else begin
      v[`FSPU_D_FRAC_W +: `FSPU_D_EXP_W] = e;
      if (clr) v[`FSPU_D_FRAC_W-1:0] = '0;
    end
    return v;
  endfunction

  task automatic issue(input fspu_pkg::fspu_opcode_e opc, input bit single, input bit cond,
                       input logic [63:0] a, input logic [63:0] b, input logic [63:0] src);
    fspu_pkg::fspu_req_t  req;
    fspu_pkg::fspu_rslt_t want;
    req = '{opcode: opc, fmt_single: single, fsel_cond: cond, oper0: a, oper1: b,
            mtvr_src0: src, tag: next_tag};
    want.data = expected_data(req);
    want.tag  = req.tag;
    next_tag  = next_tag + 1'b1;
    @(posedge forever_cpuclk);
    #2;
    in_req = req;
    in_vld = 1'b1;
    exp_q.push_back(want);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge forever_cpuclk);
      #2;
      in_vld = 1'b0;
    end
  endtask

  // Let every outstanding result come out, then report the test
  task automatic finish_test(input string name, input int errs_before);
    idle(1);
    while (rd_idx < exp_q.size()) idle(1);
    idle(2);
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic run_specials(input fspu_pkg::fspu_opcode_e opc, input string name);
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 12; i++) begin
      issue(opc, 1'b0, 1'b0, D_SPECIALS[i], D_SPECIALS[(i + 3) % 12], '0);
      issue(opc, 1'b1, 1'b0, S_SPECIALS[i], S_SPECIALS[(i + 5) % 12], '0);
    end
    finish_test(name, errs);
  endtask

  task automatic run_moves();
    int          errs;
    logic [63:0] a;
    logic [63:0] b;
    errs = err_cnt;
    a    = 64'h8123_4567_89ab_cdef;
    b    = 64'h0fed_cba9_7654_3210;
    for (int f = 0; f < 2; f++) begin
      issue(fspu_pkg::FMV_VF, f[0], 1'b0, a, b, 64'h5a5a_0000_ffff_1234);
      issue(fspu_pkg::FMV_FF, f[0], 1'b0, a, b, '0);
      issue(fspu_pkg::FMV_FH, f[0], 1'b0, a, b, '0);
      issue(fspu_pkg::FMV_XH, f[0], 1'b0, a, b, '0);
      issue(fspu_pkg::FMV_XH, f[0], 1'b0, b, a, '0);
      issue(fspu_pkg::FSEL, f[0], 1'b0, a, b, '0);
      issue(fspu_pkg::FSEL, f[0], 1'b1, a, b, '0);
    end
    for (int c = 10; c < 16; c++) begin
      issue(fspu_pkg::fspu_opcode_e'(c[3:0]), 1'b0, 1'b1, a, b, a);
    end
    finish_test("moves_select_reserved", errs);
  endtask

  task automatic run_random();
    int errs;
    bit single;
    errs = err_cnt;
    for (int n = 0; n < RAND_REQS; n++) begin
      single = 1'($urandom_range(0, 1));
      issue(fspu_pkg::fspu_opcode_e'(4'($urandom_range(0, 11))), single,
            1'($urandom_range(0, 1)), rand_operand(single), rand_operand(single),
            {$urandom, $urandom});
      if ($urandom_range(0, 3) == 0) idle(1);
    end
    finish_test("random", errs);
  endtask

  initial begin
    int errs;
    void'($urandom(32'h5402_ee61));
    rst_n        = 1'b0;
    in_vld       = 1'b0;
    in_req       = '0;
    next_tag     = '0;
    tests_passed = 0;
    tests_failed = 0;
    errs         = err_cnt;
    repeat (10) @(posedge forever_cpuclk);
    #2;
    rst_n = 1'b1;
    idle(6);
    finish_test("reset_quiet", errs);
    run_specials(fspu_pkg::FCLASS, "fclass");
    run_specials(fspu_pkg::FLOGB, "flogb");
    run_specials(fspu_pkg::FSGNJ, "fsgnj");
    run_specials(fspu_pkg::FSGNJN, "fsgnjn");
    run_specials(fspu_pkg::FSGNJX, "fsgnjx");
    run_moves();
    run_random();
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
design/fspu_pkg.sv
design/fspu_pipe_reg.sv
design/fspu_decode.sv
design/fspu_double.sv
design/fspu_single.sv
design/fspu_ex1_stage.sv
design/fspu_top.sv
bench/tb_fspu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fspu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
